// ==== dualcore_consts.svh ====
`ifndef DUALCORE_CONSTS_SVH
`define DUALCORE_CONSTS_SVH

// ====================
// uart timing
// ====================

// clock cycles per uart bit.
`define DC_BAUD_DIV 4

// ====================
// message layout
// ====================

// bytes sent by each core per run.
`define DC_MSG_LEN 8

// first character of each core's message.
`define DC_CORE0_BASE 8'h41
`define DC_CORE1_BASE 8'h61

`endif

// ==== dualcore_pkg.sv ====
package dualcore_pkg;

	// ====================
	// core to combiner
	// ====================

	// one byte offered by a message core.
	// valid stays high until the combiner grants it.
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} core_req_t;

	// ====================
	// board status
	// ====================

	// led order from msb to lsb.
	typedef struct packed {
		logic core0_busy;
		logic core1_busy;
		logic tx_busy;
		logic all_done;
	} led_t;

endpackage

// ==== msg_core.sv ====
`timescale 1ns/1ps
`include "dualcore_consts.svh"

module msg_core #(
	parameter logic [7:0] BASE_CHAR = 8'h41
) (
	input  logic                    clk,
	input  logic                    i_arst_n,
	input  logic                    i_start,
	input  logic                    i_clear,
	input  logic                    i_grant,
	output dualcore_pkg::core_req_t o_req,
	output logic                    o_busy,
	output logic                    o_done
);

	localparam int IDX_W = $clog2(`DC_MSG_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`DC_MSG_LEN - 1);

	logic [2:0]       start_sr;
	logic [2:0]       clear_sr;
	logic             start_rise;
	logic             clear_rise;
	logic             last_grant;
	logic             busy;
	logic             done;
	logic [IDX_W-1:0] idx;

	// ====================
	// switch sync and edge detect
	// ====================

	// two flops to synchronize, a third to find the rising edge.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			start_sr <= '0;
			clear_sr <= '0;
		end else begin
			start_sr <= {start_sr[1:0], i_start};
			clear_sr <= {clear_sr[1:0], i_clear};
		end
	end

	assign start_rise = start_sr[1] & ~start_sr[2];
	assign clear_rise = clear_sr[1] & ~clear_sr[2];

	// ====================
	// message sequencing
	// ====================

	assign last_grant = busy && i_grant && (idx == LAST_IDX);

	// a start edge during a run is dropped.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy <= 1'b0;
			idx  <= '0;
		end else if (start_rise && !busy) begin
			busy <= 1'b1;
			idx  <= '0;
		end else if (busy && i_grant) begin
			if (idx == LAST_IDX) begin
				busy <= 1'b0;
				idx  <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// done holds across restarts until the clear switch rises.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			done <= 1'b0;
		end else if (clear_rise) begin
			done <= 1'b0;
		end else if (last_grant) begin
			done <= 1'b1;
		end
	end

	always_comb begin
		o_req.valid = busy;
		o_req.data  = BASE_CHAR + 8'(idx);
	end

	assign o_busy = busy;
	assign o_done = done;

	// an offered byte may not change until the combiner takes it.
	assert property (@(posedge clk) disable iff (!i_arst_n)
		o_req.valid && !i_grant |=> o_req.valid && $stable(o_req.data));

endmodule

// ==== uart_tx_arb.sv ====
`timescale 1ns/1ps
`include "dualcore_consts.svh"

module uart_tx_arb (
	input  logic                    clk,
	input  logic                    i_arst_n,
	input  dualcore_pkg::core_req_t i_req0,
	input  dualcore_pkg::core_req_t i_req1,
	output logic                    o_grant0,
	output logic                    o_grant1,
	output logic                    o_tx,
	output logic                    o_busy
);

	localparam int BAUD_W = $clog2(`DC_BAUD_DIV + 1);
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`DC_BAUD_DIV - 1);
	// start bit, eight data bits, stop bit.
	localparam logic [3:0] BIT_LAST = 4'd9;

	logic              rr_ptr;
	logic              busy;
	logic              grant_any;
	logic              bit_end;
	logic [9:0]        frame;
	logic [BAUD_W-1:0] baud_cnt;
	logic [3:0]        bit_cnt;

	// ====================
	// round-robin grant
	// ====================

	// rr_ptr low favours core 0 when both ask.
	always_comb begin
		o_grant0 = 1'b0;
		o_grant1 = 1'b0;
		if (!busy) begin
			if (i_req0.valid && (!i_req1.valid || !rr_ptr)) begin
				o_grant0 = 1'b1;
			end else if (i_req1.valid) begin
				o_grant1 = 1'b1;
			end
		end
	end

	assign grant_any = o_grant0 | o_grant1;

	// after any grant the other core gets priority.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rr_ptr <= 1'b0;
		end else if (o_grant0) begin
			rr_ptr <= 1'b1;
		end else if (o_grant1) begin
			rr_ptr <= 1'b0;
		end
	end

	// ====================
	// 8n1 serializer
	// ====================

	assign bit_end = busy && (baud_cnt == BAUD_LAST);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else if (grant_any) begin
			busy     <= 1'b1;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else if (busy) begin
			if (bit_end) begin
				baud_cnt <= '0;
				if (bit_cnt == BIT_LAST) begin
					busy <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// frame bit 0 is on the line and the frame shifts out lsb first.
	always_ff @(posedge clk) begin
		if (grant_any) begin
			frame <= {1'b1, (o_grant0 ? i_req0.data : i_req1.data), 1'b0};
		end else if (bit_end) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

	assign o_tx   = busy ? frame[0] : 1'b1;
	assign o_busy = busy;

	// at most one core wins a grant.
	assert property (@(posedge clk) disable iff (!i_arst_n)
		!(o_grant0 && o_grant1));

	// a grant from idle starts a frame with the start bit on the next cycle.
	assert property (@(posedge clk) disable iff (!i_arst_n)
		grant_any |-> !busy ##1 (busy && !o_tx));

endmodule

// ==== dualcore_sys.sv ====
`timescale 1ns/1ps
`include "dualcore_consts.svh"

module dualcore_sys (
	input  logic               clk,
	input  logic               i_arst_n,
	input  logic               i_sw1,
	input  logic               i_sw2,
	input  logic               i_sw3,
	output dualcore_pkg::led_t o_led,
	output logic               o_uart_tx
);

	dualcore_pkg::core_req_t core0_req;
	dualcore_pkg::core_req_t core1_req;
	logic                    grant0;
	logic                    grant1;
	logic                    core0_busy;
	logic                    core1_busy;
	logic                    core0_done;
	logic                    core1_done;
	logic                    tx_busy;

	// ====================
	// message cores
	// ====================

	// sw3 clears the done flags of both cores.
	msg_core #(
		.BASE_CHAR (`DC_CORE0_BASE)
	) u_core0 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_start  (i_sw1),
		.i_clear  (i_sw3),
		.i_grant  (grant0),
		.o_req    (core0_req),
		.o_busy   (core0_busy),
		.o_done   (core0_done)
	);

	msg_core #(
		.BASE_CHAR (`DC_CORE1_BASE)
	) u_core1 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_start  (i_sw2),
		.i_clear  (i_sw3),
		.i_grant  (grant1),
		.o_req    (core1_req),
		.o_busy   (core1_busy),
		.o_done   (core1_done)
	);

	// ====================
	// shared uart
	// ====================

	uart_tx_arb u_arb (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_req0   (core0_req),
		.i_req1   (core1_req),
		.o_grant0 (grant0),
		.o_grant1 (grant1),
		.o_tx     (o_uart_tx),
		.o_busy   (tx_busy)
	);

	always_comb begin
		o_led.core0_busy = core0_busy;
		o_led.core1_busy = core1_busy;
		o_led.tx_busy    = tx_busy;
		o_led.all_done   = core0_done & core1_done;
	end

endmodule

// ==== tb_uart_rx.sv ====
`timescale 1ns/1ps
`include "dualcore_consts.svh"

module tb_uart_rx (
	input  logic       clk,
	input  logic       i_rx,
	output logic       o_valid,
	output logic [7:0] o_data,
	output logic       o_frame_err
);

	logic [7:0] shift;
	logic       stop_bit;

	// 8n1 receiver, samples each bit in its middle.
	initial begin
		o_valid     <= 1'b0;
		o_data      <= 8'h00;
		o_frame_err <= 1'b0;
		forever begin
			@(posedge clk);
			o_valid     <= 1'b0;
			o_frame_err <= 1'b0;
			if (i_rx == 1'b0) begin
				// move to the middle of the start bit.
				repeat (`DC_BAUD_DIV / 2) @(posedge clk);
				if (i_rx == 1'b0) begin
					for (int b = 0; b < 8; b++) begin
						repeat (`DC_BAUD_DIV) @(posedge clk);
						shift[b] = i_rx;
					end
					repeat (`DC_BAUD_DIV) @(posedge clk);
					stop_bit = i_rx;
					o_data      <= shift;
					o_valid     <= stop_bit;
					o_frame_err <= ~stop_bit;
				end
			end
		end
	end

endmodule

// ==== dualcore_sys_tb.sv ====
`timescale 1ns/1ps
`include "dualcore_consts.svh"

module dualcore_sys_tb;

	localparam int NUM_ROWS       = 4;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 2 * `DC_MSG_LEN * 41 + 200;
	localparam logic [1:0] ORD_C0 = 2'd0;
	localparam logic [1:0] ORD_C1 = 2'd1;
	localparam logic [1:0] ORD_IL = 2'd2;

	// one row of the stimulus table.
	typedef struct packed {
		logic       clear;     // pulse sw3 before the start.
		logic [1:0] start;     // bit 0 is sw1, bit 1 is sw2.
		logic       restart;   // extra sw1 pulse mid-run.
		logic [4:0] exp_count;
		logic [1:0] order;
		logic       exp_done;
	} test_row_t;

	logic               clk;
	logic               arst_n;
	logic               sw1;
	logic               sw2;
	logic               sw3;
	dualcore_pkg::led_t led;
	logic               uart_tx;
	logic               rx_valid;
	logic [7:0]         rx_data;
	logic               rx_ferr;
	logic [7:0]         rx_q[$];
	test_row_t          test_rows[NUM_ROWS];
	string              row_names[NUM_ROWS];
	integer             seed = 32'h2d4ad247;
	int                 err_count = 0;
	int                 tests_run = 0;
	int                 tests_failed = 0;
	int                 cycle_cnt = 0;

	dualcore_sys u_dut (
		.clk       (clk),
		.i_arst_n  (arst_n),
		.i_sw1     (sw1),
		.i_sw2     (sw2),
		.i_sw3     (sw3),
		.o_led     (led),
		.o_uart_tx (uart_tx)
	);

	tb_uart_rx u_rx (
		.clk         (clk),
		.i_rx        (uart_tx),
		.o_valid     (rx_valid),
		.o_data      (rx_data),
		.o_frame_err (rx_ferr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ====================
	// helpers
	// ====================

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s got %0h expected %0h", $time, what, actual, expected);
			err_count++;
		end
	endtask

	// mask bit 0 is sw1, bit 1 is sw2, bit 2 is sw3.
	task automatic pulse_switches(input logic [2:0] mask);
		@(posedge clk);
		sw1 <= mask[0];
		sw2 <= mask[1];
		sw3 <= mask[2];
		repeat (3) @(posedge clk);
		sw1 <= 1'b0;
		sw2 <= 1'b0;
		sw3 <= 1'b0;
	endtask

	// byte n of a run follows from the base characters.
	function automatic logic [7:0] expected_byte(input logic [1:0] order, input int n);
		if (order == ORD_C0) begin
			return `DC_CORE0_BASE + 8'(n);
		end else if (order == ORD_C1) begin
			return `DC_CORE1_BASE + 8'(n);
		end
		// interleaved runs alternate and start with core 0.
		return ((n % 2) == 0) ? `DC_CORE0_BASE + 8'(n / 2) : `DC_CORE1_BASE + 8'(n / 2);
	endfunction

	always @(negedge clk) begin
		if (rx_valid) begin
			rx_q.push_back(rx_data);
		end
		if (rx_ferr) begin
			$display("framing error at %0t ns: stop bit was low", $time);
			err_count++;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ====================
	// test sequence
	// ====================

	initial begin
		test_row_t row;
		int        errs_before;
		int        exp_n;
		int        wait_cycles;
		int        gap;

		arst_n <= 1'b0;
		sw1    <= 1'b0;
		sw2    <= 1'b0;
		sw3    <= 1'b0;

		// each row holds clear, start, restart, byte count, order and all_done after.
		test_rows[0] = '{1'b0, 2'b01, 1'b0, 5'(`DC_MSG_LEN), ORD_C0, 1'b0};
		test_rows[1] = '{1'b0, 2'b10, 1'b0, 5'(`DC_MSG_LEN), ORD_C1, 1'b1};
		test_rows[2] = '{1'b1, 2'b11, 1'b0, 5'(2 * `DC_MSG_LEN), ORD_IL, 1'b1};
		test_rows[3] = '{1'b0, 2'b01, 1'b1, 5'(`DC_MSG_LEN), ORD_C0, 1'b1};
		row_names[0] = "core 0 alone";
		row_names[1] = "core 1 alone";
		row_names[2] = "both cores";
		row_names[3] = "restart while busy";

		repeat (8) @(posedge clk);
		arst_n <= 1'b1;

		errs_before = err_count;
		for (int c = 0; c < 8; c++) begin
			@(posedge clk);
			check_eq(32'(led), 32'd0, "leds after reset");
			check_eq(32'(uart_tx), 32'd1, "uart line after reset");
		end
		tests_run++;
		if (err_count != errs_before) begin
			tests_failed++;
		end
		$display("test 0 reset state: %s", (err_count == errs_before) ? "pass" : "fail");

		for (int t = 0; t < NUM_ROWS; t++) begin
			row         = test_rows[t];
			exp_n       = int'(row.exp_count);
			errs_before = err_count;
			gap         = 4 + ({$random(seed)} % 8);
			repeat (gap) @(posedge clk);

			if (row.clear) begin
				pulse_switches(3'b100);
				wait_cycles = 0;
				while (led.all_done && wait_cycles < 20) begin
					@(posedge clk);
					wait_cycles++;
				end
				if (led.all_done) begin
					$display("test %0d: all_done stayed high after the clear switch", t + 1);
					err_count++;
				end
			end

			rx_q.delete();
			pulse_switches({1'b0, row.start});
			wait_cycles = 0;
			while ({led.tx_busy, led.core1_busy, led.core0_busy} != {1'b1, row.start}
				&& wait_cycles < 10) begin
				@(posedge clk);
				wait_cycles++;
			end
			check_eq(32'({led.tx_busy, led.core1_busy, led.core0_busy}),
				32'({1'b1, row.start}), "busy leds at start");

			if (row.restart) begin
				repeat (60) @(posedge clk);
				pulse_switches(3'b001);
			end

			wait_cycles = 0;
			while ((rx_q.size() < exp_n || led.core0_busy || led.core1_busy || led.tx_busy)
				&& wait_cycles < exp_n * 41 + 100) begin
				@(posedge clk);
				wait_cycles++;
			end
			// one more frame time so a stray extra byte would show up.
			repeat (10 * `DC_BAUD_DIV + 8) @(posedge clk);

			check_eq(32'({led.tx_busy, led.core1_busy, led.core0_busy}), 32'd0,
				"busy leds after run");
			if (rx_q.size() < exp_n) begin
				$display("test %0d: only %0d of %0d bytes arrived", t + 1, rx_q.size(), exp_n);
				err_count++;
			end else if (rx_q.size() > exp_n) begin
				$display("test %0d: %0d bytes arrived, %0d more than expected", t + 1,
					rx_q.size(), rx_q.size() - exp_n);
				err_count++;
			end
			for (int n = 0; n < rx_q.size() && n < exp_n; n++) begin
				check_eq(32'(rx_q[n]), 32'(expected_byte(row.order, n)),
					$sformatf("test %0d byte %0d", t + 1, n));
			end
			if (row.exp_done && !led.all_done) begin
				$display("test %0d: all_done flag is missing after the run", t + 1);
				err_count++;
			end else if (!row.exp_done && led.all_done) begin
				$display("test %0d: all_done flag is set although a core has not run", t + 1);
				err_count++;
			end

			tests_run++;
			if (err_count != errs_before) begin
				tests_failed++;
			end
			$display("test %0d %s: %s, %0d bytes", t + 1, row_names[t],
				(err_count == errs_before) ? "pass" : "fail", rx_q.size());
		end

		$display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, err_count);
		if (err_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== dualcore_sys.f ====
+incdir+.
dualcore_pkg.sv
msg_core.sv
uart_tx_arb.sv
dualcore_sys.sv
tb_uart_rx.sv
dualcore_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and check the log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	-f dualcore_sys.f \
	--top-module dualcore_sys_tb \
	--Mdir obj_dir \
	-o dualcore_sys_sim

./obj_dir/dualcore_sys_sim | tee "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
	echo "simulation reported failures"
	exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
